// File: Bender.yml
package:
  name: lcd_driver

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lcd_bus_pkg.sv
      - hdl/lcd_host_pkg.sv
      - hdl/lcd_controller.sv
      - hdl/lcd_text_formatter.sv
      - hdl/lcd_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_lcd_top.sv

// File: hdl/lcd_bus_pkg.sv
package lcd_bus_pkg;

	// eight data lines of the display bus
	typedef logic [7:0] lcd_data_t;

	// display data ram address, low seven bits of a set-address instruction
	typedef logic [6:0] lcd_ddram_addr_t;

	// instruction bases, option bits are or-ed in by the sender
	typedef enum logic [7:0] {
		CLEAR        = 8'h01,
		ENTRY_MODE   = 8'h04, // | increment, shift
		DISPLAY_CTRL = 8'h08, // | display on, cursor on, blink
		FUNCTION_SET = 8'h30, // | lines, font; 8-bit bus fixed
		SET_DDRAM    = 8'h80  // | address
	} lcd_instr_e;

	// init configuration, msb first as on the cfg input pins
	typedef struct packed {
		logic lines;      // 1 = two display lines
		logic font;       // 1 = 5x10 dots
		logic display_on;
		logic cursor_on;
		logic blink;
		logic increment;  // address counter direction
		logic shift;      // shift display on write
	} lcd_init_cfg_t;

	// controller sequencing
	typedef enum logic [1:0] {
		POWER_UP = 2'd0,
		INIT     = 2'd1,
		IDLE     = 2'd2,
		STROBE   = 2'd3
	} ctrl_state_e;

endpackage

// File: hdl/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// clock cycles per microsecond, kept at 1 for short simulations
`define LCD_CLK_PER_US 1

// display geometry
`define LCD_COLUMNS 16
`define LCD_ROWS 2
`define LCD_ROW1_ADDR 7'h40 // ddram address of row 1, column 0

// delay counter width, must hold 500 us worth of cycles
`define LCD_CNT_BITS 14

`endif

// File: hdl/lcd_controller.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module lcd_controller (
	input  logic                      clk,
	input  logic                      arst_n,
	input  lcd_bus_pkg::lcd_init_cfg_t init_cfg,
	input  logic                      word_valid,
	input  logic                      word_rs,
	input  lcd_bus_pkg::lcd_data_t     word_data,
	output logic                      busy,
	output logic                      e,
	output logic                      rs,
	output logic                      rw,
	output lcd_bus_pkg::lcd_data_t     lcd_data
);

	import lcd_bus_pkg::*;

	typedef logic [`LCD_CNT_BITS-1:0] cnt_t;

	// power-up wait
	localparam cnt_t t_power_up = cnt_t'(500 * `LCD_CLK_PER_US);

	// init windows, each command has e high for 10 us then a settle wait
	localparam cnt_t t_fs_end    = cnt_t'(10 * `LCD_CLK_PER_US);
	localparam cnt_t t_dc_start  = cnt_t'(60 * `LCD_CLK_PER_US);
	localparam cnt_t t_dc_end    = cnt_t'(70 * `LCD_CLK_PER_US);
	localparam cnt_t t_clr_start = cnt_t'(120 * `LCD_CLK_PER_US);
	localparam cnt_t t_clr_end   = cnt_t'(130 * `LCD_CLK_PER_US);
	localparam cnt_t t_em_start  = cnt_t'(330 * `LCD_CLK_PER_US);
	localparam cnt_t t_em_end    = cnt_t'(340 * `LCD_CLK_PER_US);
	localparam cnt_t t_init_end  = cnt_t'(440 * `LCD_CLK_PER_US);

	// write strobe, e low again from 14 us, idle at 50 us
	localparam cnt_t t_e_rise     = cnt_t'(`LCD_CLK_PER_US);
	localparam cnt_t t_e_fall     = cnt_t'(14 * `LCD_CLK_PER_US);
	localparam cnt_t t_strobe_end = cnt_t'(50 * `LCD_CLK_PER_US);

	ctrl_state_e state;
	cnt_t        cnt;
	cnt_t        cnt_nxt;

	lcd_data_t func_set_word;
	lcd_data_t disp_ctrl_word;
	lcd_data_t entry_mode_word;
	lcd_data_t init_word;
	logic      init_e;

	assign cnt_nxt = cnt + 1'b1;
	assign rw      = 1'b0; // write only, no busy-flag reads

	// init instructions from the cfg bits
	assign func_set_word   = lcd_data_t'(FUNCTION_SET)
		| {4'b0000, init_cfg.lines, init_cfg.font, 2'b00};
	assign disp_ctrl_word  = lcd_data_t'(DISPLAY_CTRL)
		| {5'b00000, init_cfg.display_on, init_cfg.cursor_on, init_cfg.blink};
	assign entry_mode_word = lcd_data_t'(ENTRY_MODE)
		| {6'b000000, init_cfg.increment, init_cfg.shift};

	// which init window the counter is in
	always_comb begin
		init_e    = 1'b0;
		init_word = '0;
		if (cnt < t_fs_end) begin
			init_e    = 1'b1;
			init_word = func_set_word;
		end else if (cnt >= t_dc_start && cnt < t_dc_end) begin
			init_e    = 1'b1;
			init_word = disp_ctrl_word;
		end else if (cnt >= t_clr_start && cnt < t_clr_end) begin
			init_e    = 1'b1;
			init_word = lcd_data_t'(CLEAR);
		end else if (cnt >= t_em_start && cnt < t_em_end) begin
			init_e    = 1'b1;
			init_word = entry_mode_word;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= POWER_UP;
			cnt      <= '0;
			busy     <= 1'b1;
			e        <= 1'b0;
			rs       <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
				POWER_UP: begin
					if (cnt_nxt == t_power_up) begin
						cnt   <= '0;
						state <= INIT;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				INIT: begin
					lcd_data <= init_word; // data before e, settles with it
					e        <= init_e;
					rs       <= 1'b0;
					if (cnt_nxt == t_init_end) begin
						cnt   <= '0;
						busy  <= 1'b0;
						state <= IDLE;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				IDLE: begin
					e   <= 1'b0;
					cnt <= '0;
					if (word_valid) begin
						busy     <= 1'b1; // acceptance
						rs       <= word_rs;
						lcd_data <= word_data;
						state    <= STROBE;
					end else begin
						busy     <= 1'b0;
						rs       <= 1'b0;
						lcd_data <= '0;
					end
				end
				STROBE: begin
					if (cnt_nxt == t_strobe_end) begin
						cnt      <= '0;
						e        <= 1'b0;
						busy     <= 1'b0;
						rs       <= 1'b0;
						lcd_data <= '0;
						state    <= IDLE;
					end else begin
						cnt <= cnt_nxt;
						e   <= (cnt_nxt >= t_e_rise) && (cnt_nxt < t_e_fall);
					end
				end
				default: begin
					state <= POWER_UP;
				end
			endcase
		end
	end

endmodule

// File: hdl/lcd_host_pkg.sv
package lcd_host_pkg;

	// operations the host can request
	typedef enum logic [1:0] {
		OP_CHAR    = 2'd0, // print host_data at the cursor
		OP_CMD     = 2'd1, // raw instruction byte
		OP_NEWLINE = 2'd2, // jump to start of the other row
		OP_CLEAR   = 2'd3  // clear screen, cursor home
	} host_op_e;

	// formatter handshake sequencing
	typedef enum logic [1:0] {
		WAIT_REQ  = 2'd0, // idle, ack low
		SEND_MAIN = 2'd1, // first bus word in flight
		SEND_ADDR = 2'd2, // wrap address word in flight
		ACK_HOLD  = 2'd3  // wait for strobe end, then ack until req drops
	} fmt_state_e;

endpackage

// File: hdl/lcd_text_formatter.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module lcd_text_formatter (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   req,
	input  lcd_host_pkg::host_op_e  host_op,
	input  lcd_bus_pkg::lcd_data_t  host_data,
	output logic                   ack,
	input  logic                   busy,
	output logic                   word_valid,
	output logic                   word_rs,
	output lcd_bus_pkg::lcd_data_t  word_data
);

	import lcd_bus_pkg::*;
	import lcd_host_pkg::*;

	localparam int row_bits = $clog2(`LCD_ROWS);
	localparam int col_bits = $clog2(`LCD_COLUMNS);

	typedef logic [row_bits-1:0] row_t;
	typedef logic [col_bits-1:0] col_t;

	localparam row_t last_row = row_t'(`LCD_ROWS - 1);
	localparam col_t last_col = col_t'(`LCD_COLUMNS - 1);

	fmt_state_e      state;
	row_t            row;
	col_t            col;
	row_t            next_row;
	lcd_ddram_addr_t next_row_addr;
	lcd_data_t       set_addr_word;
	lcd_data_t       addr_data;
	logic            addr_pending;
	logic            busy_q;
	logic            accepted;
	logic            main_rs;
	lcd_data_t       main_data;

	// controller took our word: busy rises while we present it
	assign accepted = word_valid && busy && !busy_q;

	// start address of the row after the current one
	assign next_row      = (row == last_row) ? '0 : row + 1'b1;
	assign next_row_addr = (next_row == '0) ? '0 : `LCD_ROW1_ADDR;
	assign set_addr_word = lcd_data_t'(SET_DDRAM) | {1'b0, next_row_addr};

	// first bus word of the requested op
	always_comb begin
		main_rs   = 1'b0;
		main_data = host_data; // OP_CMD passes through
		case (host_op)
			OP_CHAR:    main_rs = 1'b1;
			OP_NEWLINE: main_data = set_addr_word;
			OP_CLEAR:   main_data = lcd_data_t'(CLEAR);
			default:    main_data = host_data;
		endcase
	end

	// bus word payload
	always_ff @(posedge clk) begin
		if (state == WAIT_REQ && req) begin
			word_rs   <= main_rs;
			word_data <= main_data;
			addr_data <= set_addr_word; // only sent on a row wrap
		end else if (state == SEND_ADDR && !word_valid) begin
			word_rs   <= 1'b0;
			word_data <= addr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= WAIT_REQ;
			word_valid   <= 1'b0;
			ack          <= 1'b0;
			row          <= '0;
			col          <= '0;
			addr_pending <= 1'b0;
			busy_q       <= 1'b1; // controller comes out of reset busy
		end else begin
			busy_q <= busy;
			case (state)
				WAIT_REQ: begin
					if (req) begin
						word_valid   <= 1'b1;
						addr_pending <= 1'b0;
						state        <= SEND_MAIN;
						case (host_op)
							OP_CHAR: begin
								if (col == last_col) begin
									col          <= '0;
									row          <= next_row;
									addr_pending <= 1'b1;
								end else begin
									col <= col + 1'b1;
								end
							end
							OP_NEWLINE: begin
								row <= next_row;
								col <= '0;
							end
							OP_CLEAR: begin
								row <= '0;
								col <= '0;
							end
							default: begin
								col <= col; // raw command, cursor untouched
							end
						endcase
					end
				end
				SEND_MAIN: begin
					if (accepted) begin
						word_valid <= 1'b0;
						state      <= addr_pending ? SEND_ADDR : ACK_HOLD;
					end
				end
				SEND_ADDR: begin
					if (accepted) begin
						word_valid <= 1'b0;
						state      <= ACK_HOLD;
					end else if (!word_valid) begin
						word_valid <= 1'b1; // present after the drop cycle
					end
				end
				ACK_HOLD: begin
					if (!ack && !busy) begin
						ack <= 1'b1; // last strobe finished
					end else if (ack && !req) begin
						ack   <= 1'b0;
						state <= WAIT_REQ;
					end
				end
				default: begin
					state <= WAIT_REQ;
				end
			endcase
		end
	end

endmodule

// File: hdl/lcd_top.sv
`timescale 1ns/1ns

module lcd_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      req,
	input  lcd_host_pkg::host_op_e     host_op,
	input  lcd_bus_pkg::lcd_data_t     host_data,
	input  lcd_bus_pkg::lcd_init_cfg_t init_cfg,
	output logic                      ack,
	output logic                      busy,
	output logic                      e,
	output logic                      rs,
	output logic                      rw,
	output lcd_bus_pkg::lcd_data_t     lcd_data
);

	import lcd_bus_pkg::*;

	// formatter to controller word channel
	logic      word_valid;
	logic      word_rs;
	lcd_data_t word_data;

	lcd_text_formatter formatter_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.host_op    (host_op),
		.host_data  (host_data),
		.ack        (ack),
		.busy       (busy),
		.word_valid (word_valid),
		.word_rs    (word_rs),
		.word_data  (word_data)
	);

	lcd_controller controller_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.init_cfg   (init_cfg),
		.word_valid (word_valid),
		.word_rs    (word_rs),
		.word_data  (word_data),
		.busy       (busy), // also seen by the host
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

endmodule

// File: project.f
+incdir+hdl
hdl/lcd_bus_pkg.sv
hdl/lcd_host_pkg.sv
hdl/lcd_controller.sv
hdl/lcd_text_formatter.sv
hdl/lcd_top.sv
verification/tb_lcd_top.sv

// File: verification/tb_lcd_top.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module tb_lcd_top;

	import lcd_bus_pkg::*;
	import lcd_host_pkg::*;

	// one host operation and the bus words it must produce
	typedef struct packed {
		host_op_e   op;
		lcd_data_t  data;
		logic [1:0] nwords;
		logic       rs0;
		lcd_data_t  exp0;
		logic       rs1;
		lcd_data_t  exp1;
	} entry_t;

	// two lines, 5x8 font, display and cursor on, no blink, increment, no shift
	localparam lcd_init_cfg_t cfg = 7'b1011010;

	logic          clk;
	logic          arst_n;
	logic          req;
	host_op_e      host_op;
	lcd_data_t     host_data;
	lcd_init_cfg_t init_cfg;
	logic          ack;
	logic          busy;
	logic          e;
	logic          rs;
	logic          rw;
	lcd_data_t     lcd_data;

	entry_t     table_q[$];
	logic [8:0] bus_q[$];          // {rs, data} per e pulse
	logic       e_prev = 1'b0;
	int         cycles = 0;
	int         cycle_limit = 0;
	int         model_row;
	int         model_col;

	lcd_top dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.host_op   (host_op),
		.host_data (host_data),
		.init_cfg  (init_cfg),
		.ack       (ack),
		.busy      (busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// bus monitor sampled mid-cycle
	always @(negedge clk) begin
		if (e && !e_prev) begin
			bus_q.push_back({rs, lcd_data});
		end
		e_prev = e;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d clock cycles, the DUT never finished", cycles);
			$display("Test failed");
			$fatal(1, "run aborted");
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input string what, input logic got_rs, input lcd_data_t got_data,
			input logic exp_rs, input lcd_data_t exp_data);
		if (got_rs !== exp_rs || got_data !== exp_data) begin
			fail_now($sformatf("ERR %0t ns: %s expected rs=%b data=%h, got rs=%b data=%h",
				$time, what, exp_rs, exp_data, got_rs, got_data));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("ERR %0t ns: %s expected %b, got %b", $time, name, exp, got));
		end
	endtask

	task automatic expect_word(input string what, input logic exp_rs, input lcd_data_t exp_data);
		logic [8:0] w;
		if (bus_q.size() == 0) begin
			fail_now($sformatf("%s: no write was seen on the display pins", what));
		end else begin
			w = bus_q.pop_front();
			check_word(what, w[8], w[7:0], exp_rs, exp_data);
		end
	endtask

	// set-address word for the start of a row
	function automatic lcd_data_t row_start_word(input int row);
		return (row == 0) ? 8'h80 : (8'h80 | {1'b0, `LCD_ROW1_ADDR});
	endfunction

	// expected words follow a cursor model of the formatter
	task automatic add_entry(input host_op_e op, input lcd_data_t data);
		entry_t ent;
		ent        = '0;
		ent.op     = op;
		ent.data   = data;
		ent.nwords = 2'd1;
		case (op)
			OP_CHAR: begin
				ent.rs0  = 1'b1;
				ent.exp0 = data;
				if (model_col == `LCD_COLUMNS - 1) begin
					model_col  = 0;
					model_row  = (model_row + 1) % `LCD_ROWS;
					ent.nwords = 2'd2; // row full so the address word follows
					ent.exp1   = row_start_word(model_row);
				end else begin
					model_col = model_col + 1;
				end
			end
			OP_NEWLINE: begin
				model_row = (model_row + 1) % `LCD_ROWS;
				model_col = 0;
				ent.exp0  = row_start_word(model_row);
			end
			OP_CLEAR: begin
				model_row = 0;
				model_col = 0;
				ent.exp0  = 8'h01;
			end
			default: ent.exp0 = data; // raw command
		endcase
		table_q.push_back(ent);
	endtask

	task automatic add_chars(input int count);
		repeat (count) begin
			add_entry(OP_CHAR, lcd_data_t'(32'h20 + ($urandom % 95))); // printable ascii
		end
	endtask

	initial begin
		entry_t    ent;
		lcd_data_t exp_fs;
		lcd_data_t exp_dc;
		lcd_data_t exp_em;
		void'($urandom(32'h726e));
		arst_n    = 1'b0;
		req       = 1'b0;
		host_op   = OP_CHAR;
		host_data = '0;
		init_cfg  = cfg;
		model_row = 0;
		model_col = 0;

		add_chars(16);             // wrap to row 1
		add_entry(OP_CMD, 8'h0C);
		add_chars(16);             // wrap back to row 0
		add_chars(3);
		add_entry(OP_NEWLINE, 8'h00);
		add_entry(OP_NEWLINE, 8'h00);
		add_entry(OP_NEWLINE, 8'h00);
		add_chars(5);              // clear from row 1, column 5
		add_entry(OP_CLEAR, 8'h00);
		add_chars(16);             // wrap proves clear went home
		cycle_limit = 1000 * `LCD_CLK_PER_US + 2 * 55 * `LCD_CLK_PER_US * table_q.size() + 200;

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("busy after reset", busy, 1'b1);
		check_flag("ack after reset", ack, 1'b0);
		check_flag("e after reset", e, 1'b0);
		check_word("bus after reset", rs, lcd_data, 1'b0, 8'h00);

		// init sequence from the cfg bits
		do @(negedge clk); while (busy !== 1'b0);
		// hd44780 option fields are N F at bits 3:2, D C B at 2:0, I/D S at 1:0
		exp_fs    = 8'h30;
		exp_fs[3] = cfg.lines;
		exp_fs[2] = cfg.font;
		exp_dc    = 8'h08;
		exp_dc[2] = cfg.display_on;
		exp_dc[1] = cfg.cursor_on;
		exp_dc[0] = cfg.blink;
		exp_em    = 8'h04;
		exp_em[1] = cfg.increment;
		exp_em[0] = cfg.shift;
		expect_word("init function set", 1'b0, exp_fs);
		expect_word("init display control", 1'b0, exp_dc);
		expect_word("init clear", 1'b0, 8'h01);
		expect_word("init entry mode", 1'b0, exp_em);
		if (bus_q.size() != 0) begin
			fail_now("more than four writes were seen during initialization");
		end

		foreach (table_q[i]) begin
			ent = table_q[i];
			@(posedge clk);
			req       <= 1'b1;
			host_op   <= ent.op;
			host_data <= ent.data;
			do @(negedge clk); while (ack !== 1'b1);
			@(posedge clk);
			req <= 1'b0;
			do @(negedge clk); while (ack !== 1'b0);
			expect_word($sformatf("entry %0d word 0", i), ent.rs0, ent.exp0);
			if (ent.nwords == 2'd2) begin
				expect_word($sformatf("entry %0d word 1", i), ent.rs1, ent.exp1);
			end
			if (bus_q.size() != 0) begin
				fail_now($sformatf("entry %0d produced more writes than expected", i));
			end
		end
		check_flag("rw", rw, 1'b0);

		$display("Test passed");
		$finish;
	end

endmodule
